/* flist.f */
+incdir+src
src/switch_pkg.sv
src/port_arbiter.sv
src/frame_deserializer.sv
src/route_serializer.sv
src/switch_fabric.sv
tests/tb_switch_fabric.sv

/* Makefile */
# Verilator simulation of the switch fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_switch_fabric
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_switch_fabric.sv */
`timescale 1ns/100ps
`include "switch_macros.svh"

module tb_switch_fabric import switch_pkg::*;
();

  localparam int p_base = int'(`ADDR_P_BASE);
  localparam int n_base = int'(`ADDR_N_BASE);
  localparam int num_n_ports = `NUM_PORTS - `NUM_P_PORTS;

  logic      core_clock;
  logic      clk1p;
  port_vec_t req;
  port_vec_t din;
  port_vec_t gnt;
  port_vec_t dout;

  int         seed = 32'h64d;
  logic       check_en = 1'b0;
  logic       exp_active = 1'b0;
  port_idx_t  exp_port = '0;
  port_vec_t  exp_gnt;
  port_vec_t  exp_dout = '0;
  port_vec_t  sched [256];
  frame_hdr_t fbits;
  int         bit_pos = 0;
  int         cyc = 0;
  int         busy_until = 0;

  switch_fabric i_switch_fabric
  (
    .core_clock (core_clock),
    .clk1p      (clk1p),
    .req        (req),
    .din        (din),
    .gnt        (gnt),
    .dout       (dout)
  );

  always #5 core_clock = ~core_clock;

  // output port for a destination or -1 for a dropped frame
  function automatic int route_of(input logic [7:0] dest);
    int d;
    d = int'(dest);
    if (d >= p_base && d < p_base + `NUM_P_PORTS)
      return d - p_base;
    else if (d >= n_base && d < n_base + num_n_ports)
      return d - n_base + `NUM_P_PORTS;
    else
      return -1;
  endfunction

  function automatic frame_hdr_t make_frame(input logic [7:0] dest);
    logic [95:0] raw;
    frame_hdr_t  f;
    raw = {$random(seed), $random(seed), $random(seed)};
    f = raw[`FRAME_BITS-1:0];
    f.dest_addr = dest;
    return f;
  endfunction

  always_comb
  begin
    exp_gnt = '0;
    if (exp_active)
      exp_gnt[exp_port] = 1'b1;
  end

  // reference model updated once per rising edge
  always @(posedge core_clock)
  begin : ref_model
    logic       next_active;
    port_idx_t  next_port;
    frame_hdr_t drain;
    int         route;
    cyc = cyc + 1;
    if (clk1p)
    begin
      foreach (sched[i])
        sched[i] = '0;
      bit_pos = 0;
      exp_active <= 1'b0;
      exp_dout   <= '0;
    end
    else
    begin
      // capture uses the grant held before this edge
      if (exp_active)
      begin
        fbits = {fbits[`FRAME_BITS-2:0], din[exp_port]};
        if (bit_pos == `FRAME_BITS - 1)
        begin
          bit_pos = 0;
          busy_until = cyc + `FRAME_BITS;
          route = route_of(fbits.dest_addr);
          drain = fbits;
          // frame bit k leaves k+1 cycles after the last bit came in
          if (route >= 0)
          begin
            for (int k = 0; k < `FRAME_BITS; k++)
            begin
              sched[8'(cyc + 1 + k)][port_idx_t'(route)] = drain[`FRAME_BITS-1];
              drain = drain << 1;
            end
          end
        end
        else
          bit_pos = bit_pos + 1;
      end
      else
        bit_pos = 0;

      next_active = exp_active;
      next_port   = exp_port;
      if (!exp_active)
      begin
        for (int i = 0; i < `NUM_PORTS; i++)
        begin
          if (!next_active && req[port_idx_t'(i)])
          begin
            next_active = 1'b1;
            next_port   = port_idx_t'(i);
          end
        end
      end
      else if (!req[exp_port])
        next_active = 1'b0;

      exp_active <= next_active;
      exp_port   <= next_port;
      exp_dout   <= sched[8'(cyc)];
      sched[8'(cyc)] = '0;
    end
  end

  a_gnt_matches: assert property (@(posedge core_clock) disable iff (!check_en)
    gnt == exp_gnt)
    else
    begin
      $display("** Error at %0t: gnt expected %b, actual %b",
        $time, $sampled(exp_gnt), $sampled(gnt));
      $display("Checks failed");
      $fatal(1, "gnt does not follow the arbiter model");
    end

  a_dout_matches: assert property (@(posedge core_clock) disable iff (!check_en)
    dout == exp_dout)
    else
    begin
      $display("** Error at %0t: dout expected %b, actual %b",
        $time, $sampled(exp_dout), $sampled(dout));
      $display("Checks failed");
      $fatal(1, "dout does not follow the routing model");
    end

  task automatic stop_on_timeout(input string why);
    $display("timeout: %s", why);
    $display("Checks failed");
    $fatal(1, "wait timed out");
  endtask

  task automatic wait_for_grant(input port_idx_t port);
    int n;
    n = 0;
    while (gnt[port] !== 1'b1)
    begin
      @(negedge core_clock);
      n = n + 1;
      if (n > 20)
        stop_on_timeout($sformatf("port %0d was never granted", port));
    end
  endtask

  task automatic wait_for_release();
    int n;
    n = 0;
    while (gnt !== '0)
    begin
      @(negedge core_clock);
      n = n + 1;
      if (n > 20)
        stop_on_timeout("grant was not released");
    end
  endtask

  // last routed bit is checked one edge after it appears
  task automatic wait_for_drain();
    int n;
    n = 0;
    while (cyc <= busy_until)
    begin
      @(negedge core_clock);
      n = n + 1;
      if (n > 250)
        stop_on_timeout("output did not drain");
    end
  endtask

  task automatic send_bits(input port_idx_t port, input frame_hdr_t f, input int nbits);
    logic [`FRAME_BITS-1:0] bits;
    bits = f;
    for (int i = 0; i < nbits; i++)
    begin
      din[port] = bits[`FRAME_BITS-1];
      bits = bits << 1;
      @(negedge core_clock);
    end
    din[port] = 1'b0;
  endtask

  task automatic run_frame(input port_idx_t port, input logic [7:0] dest);
    req[port] = 1'b1;
    wait_for_grant(port);
    send_bits(port, make_frame(dest), `FRAME_BITS);
    req[port] = 1'b0;
    wait_for_drain();
  endtask

  initial
  begin
    core_clock = 1'b0;
    clk1p = 1'b1;
    req = '0;
    din = '0;
    @(negedge core_clock);
    check_en = 1'b1;
    repeat (9) @(negedge core_clock);
    clk1p = 1'b0;
    repeat (8) @(negedge core_clock);

    // priority and hold
    req[1] = 1'b1;
    req[3] = 1'b1;
    req[6] = 1'b1;
    wait_for_grant(1);
    repeat (4) @(negedge core_clock);
    req[0] = 1'b1;
    repeat (6) @(negedge core_clock);
    req[1] = 1'b0;
    wait_for_grant(0);
    repeat (3) @(negedge core_clock);
    req = '0;
    wait_for_release();

    run_frame(4, 8'hF2);
    run_frame(8, 8'h02);
    run_frame(0, 8'h55);

    // abort after 30 bits and then send a clean frame on a fresh grant
    req[6] = 1'b1;
    wait_for_grant(6);
    send_bits(6, make_frame(8'hF1), 30);
    req[6] = 1'b0;
    wait_for_release();
    run_frame(6, 8'hF0);

    req[3] = 1'b1;
    wait_for_grant(3);
    send_bits(3, make_frame(8'h01), `FRAME_BITS);
    send_bits(3, make_frame(8'hF4), `FRAME_BITS);
    req[3] = 1'b0;
    wait_for_drain();

    $display("All checks passed");
    $finish;
  end

endmodule

/* src/switch_fabric.sv */
`timescale 1ns/100ps

module switch_fabric import switch_pkg::*;
(
  input  logic      core_clock,
  input  logic      clk1p,
  input  port_vec_t req,
  input  port_vec_t din,
  output port_vec_t gnt,
  output port_vec_t dout
);

  logic       grant_active;
  port_idx_t  grant_port;
  logic       frame_valid;
  frame_hdr_t frame;

  // stage 1, pick one source port
  port_arbiter i_port_arbiter
  (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .req          (req),
    .gnt          (gnt),
    .grant_active (grant_active),
    .grant_port   (grant_port)
  );

  // stage 2, collect its serial frames
  frame_deserializer i_frame_deserializer
  (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .din          (din),
    .grant_active (grant_active),
    .grant_port   (grant_port),
    .frame_valid  (frame_valid),
    .frame        (frame)
  );

  // stage 3, send each frame to its destination port
  route_serializer i_route_serializer
  (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .frame_valid  (frame_valid),
    .frame        (frame),
    .dout         (dout)
  );

endmodule

/* src/route_serializer.sv */
`timescale 1ns/100ps
`include "switch_macros.svh"

module route_serializer import switch_pkg::*;
(
  input  logic       core_clock,
  input  logic       clk1p,
  input  logic       frame_valid,
  input  frame_hdr_t frame,
  output port_vec_t  dout
);

  localparam int num_n_ports = `NUM_PORTS - `NUM_P_PORTS;

  logic [`FRAME_BITS-1:0] out_q;
  logic [6:0]             out_cnt_q;
  port_idx_t              out_port_q;

  logic [7:0] p_off;
  logic [7:0] n_off;
  logic       dest_known;
  port_idx_t  dest_port;
  logic       load;

  // offsets wrap below each base, so one compare covers both bounds
  assign p_off = frame.dest_addr - `ADDR_P_BASE;
  assign n_off = frame.dest_addr - `ADDR_N_BASE;

  always_comb
  begin
    dest_known = 1'b0;
    dest_port  = '0;
    if (p_off < `NUM_P_PORTS)
    begin
      dest_known = 1'b1;
      dest_port  = port_idx_t'(p_off);
    end
    else if (n_off < num_n_ports)
    begin
      dest_known = 1'b1;
      dest_port  = port_idx_t'(n_off + `NUM_P_PORTS);
    end
  end

  // unknown destinations are never loaded and simply vanish
  assign load = frame_valid && dest_known;

  always_ff @(posedge core_clock)
  begin
    if (load)
    begin
      out_q      <= frame;
      out_port_q <= dest_port;
    end
    else
    begin
      out_q <= out_q << 1;
    end
  end

  // number of bits still to appear, counting the one on the wire
  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
      out_cnt_q <= '0;
    else if (load)
      out_cnt_q <= 7'(`FRAME_BITS);
    else if (out_cnt_q != 7'd0)
      out_cnt_q <= out_cnt_q - 7'd1;
  end

  always_comb
  begin
    dout = '0;
    if (out_cnt_q != 7'd0)
      dout[out_port_q] = out_q[`FRAME_BITS-1];
  end

  a_dout_onehot: assert property (@(posedge core_clock) disable iff (clk1p)
    $onehot0(dout))
    else $error("dout drives more than one port: %b", dout);

  // capture and drain run at the same rate, so a new frame
  // only lands on an idle or just-finishing output
  a_load_aligned: assert property (@(posedge core_clock) disable iff (clk1p)
    load |-> out_cnt_q <= 7'd1)
    else $error("frame loaded with %0d bits still pending", out_cnt_q);

endmodule

/* src/frame_deserializer.sv */
`timescale 1ns/100ps
`include "switch_macros.svh"

module frame_deserializer import switch_pkg::*;
(
  input  logic       core_clock,
  input  logic       clk1p,
  input  port_vec_t  din,
  input  logic       grant_active,
  input  port_idx_t  grant_port,
  output logic       frame_valid,
  output frame_hdr_t frame
);

  logic [`FRAME_BITS-1:0] shift_q;
  logic [6:0]             bit_cnt_q;
  logic                   serial_bit;
  logic                   last_bit;

  // serial input of whichever port holds the grant
  assign serial_bit = din[grant_port];

  // the 80th bit of the current frame is on the wire
  assign last_bit = (bit_cnt_q == 7'(`FRAME_BITS - 1));

  // msb arrives first, so new bits enter at the bottom
  always_ff @(posedge core_clock)
  begin
    if (grant_active)
      shift_q <= {shift_q[`FRAME_BITS-2:0], serial_bit};
  end

  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
    begin
      bit_cnt_q   <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= grant_active && last_bit;
      if (!grant_active)
      begin
        // partial frame is lost when the grant goes away
        bit_cnt_q <= '0;
      end
      else if (last_bit)
      begin
        bit_cnt_q <= '0;
      end
      else
      begin
        bit_cnt_q <= bit_cnt_q + 7'd1;
      end
    end
  end

  // shift register holds the whole frame during the strobe cycle
  assign frame = frame_hdr_t'(shift_q);

  a_valid_single: assert property (@(posedge core_clock) disable iff (clk1p)
    frame_valid |=> !frame_valid)
    else $error("frame_valid held for two cycles");

endmodule

/* src/port_arbiter.sv */
`timescale 1ns/100ps

module port_arbiter import switch_pkg::*;
(
  input  logic      core_clock,
  input  logic      clk1p,
  input  port_vec_t req,
  output port_vec_t gnt,
  output logic      grant_active,
  output port_idx_t grant_port
);

  // spare index code that marks the idle state
  localparam port_idx_t arb_idle = 4'hf;

  port_idx_t state_q;
  port_idx_t state_d;

  // lowest requesting index wins from idle, a held grant
  // stays until its own request drops
  always_comb
  begin
    state_d = state_q;
    if (state_q == arb_idle)
    begin
      for (int i = $bits(port_vec_t) - 1; i >= 0; i--)
      begin
        if (req[i])
          state_d = port_idx_t'(i);
      end
    end
    else if (!req[state_q])
    begin
      // always back to idle first, no direct handover
      state_d = arb_idle;
    end
  end

  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
      state_q <= arb_idle;
    else
      state_q <= state_d;
  end

  assign grant_active = (state_q != arb_idle);
  assign grant_port   = state_q;

  // one-hot decode of the held port
  always_comb
  begin
    gnt = '0;
    if (grant_active)
      gnt[state_q] = 1'b1;
  end

  a_gnt_onehot: assert property (@(posedge core_clock) disable iff (clk1p)
    $onehot0(gnt))
    else $error("gnt has more than one bit set: %b", gnt);

  // a grant bit may only rise for a port that was requesting
  a_gnt_needs_req: assert property (@(posedge core_clock) disable iff (clk1p)
    ((gnt & ~$past(gnt)) & ~$past(req)) == '0)
    else $error("gnt %b rose without request %b", gnt, $past(req));

endmodule

/* src/switch_pkg.sv */
`include "switch_macros.svh"

package switch_pkg;

  // one bit per switch port, bit i is port i
  typedef logic [`NUM_PORTS-1:0] port_vec_t;

  // port number, wide enough for all nine ports plus spare codes
  typedef logic [3:0] port_idx_t;

  // frame as it arrives on the wire, first field in the top bits
  typedef struct packed
  {
    logic [7:0]  preamble;
    logic [7:0]  src_addr;
    logic [7:0]  dest_addr;
    logic [7:0]  clock_freq;
    logic [15:0] data_length;
    logic [15:0] data_size;
    logic [15:0] data_crc;
  } frame_hdr_t;

endpackage

/* src/switch_macros.svh */
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

// port count, p ports occupy the low indices
`define NUM_PORTS    9
`define NUM_P_PORTS  5

// serial frame length, header fields only
`define FRAME_BITS   80

// destination address of the first port in each group
`define ADDR_P_BASE  8'hF0
`define ADDR_N_BASE  8'h00

`endif
